//--- include/approx_mul_macros.svh
`ifndef APPROX_MUL_MACROS_SVH
`define APPROX_MUL_MACROS_SVH

// ----------------------------------------------------------------------
// operand geometry.
// ----------------------------------------------------------------------

// operand width.
`define A_W 8

// top-level split, high part sits above the low part.
`define HI_W 3
`define LO_W 5

// ----------------------------------------------------------------------
// lower-or bit counts, as used in approximate mode.
// ----------------------------------------------------------------------

// exact adders (cross terms and the 3x3 products).
`define LOR_NONE 0

// second adder inside the 5x5 low product.
`define LOR_LOW5 1

// final alignment adder.
`define LOR_FINAL 2

`endif

//--- design/mul_mode_pkg.sv
package mul_mode_pkg;

    // ----------------------------------------------------------------------
    // accuracy mode, chosen per operation.
    // ----------------------------------------------------------------------

    typedef enum logic {
        MODE_APPROX = 1'b0,
        MODE_EXACT  = 1'b1
    } mode_e;

    // lower-or width that one adder really applies.
    // level is the width that adder uses in approximate mode.
    function automatic int unsigned lor_bits(mode_e mode, int unsigned level);
        int unsigned bits;
        case (mode)
            MODE_EXACT: begin
                bits = 0;
            end
            default: begin
                bits = level;
            end
        endcase
        return bits;
    endfunction

endpackage

//--- design/mul_arith_pkg.sv
`include "approx_mul_macros.svh"

package mul_arith_pkg;

    // ----------------------------------------------------------------------
    // datapath word types.
    // ----------------------------------------------------------------------

    // one unsigned operand.
    typedef logic [`A_W-1:0] operand_t;

    // full product.
    typedef logic [2*`A_W-1:0] product_t;

    // high x high diagonal product.
    typedef logic [2*`HI_W-1:0] hi_prod_t;

    // low x low diagonal product.
    typedef logic [2*`LO_W-1:0] lo_prod_t;

    // sum of both cross products, one bit above a single 3x5 term.
    typedef logic [`HI_W+`LO_W:0] cross_sum_t;

endpackage

//--- design/lor_adder.sv
module lor_adder #(
    parameter int WIDTH_A = 8,
    parameter int WIDTH_B = 8,
    parameter int LOR     = 0
) (
    input  logic [WIDTH_A-1:0]                                 a,
    input  logic [WIDTH_B-1:0]                                 b,
    input  logic                                               exact,
    output logic [((WIDTH_A > WIDTH_B) ? WIDTH_A : WIDTH_B):0] sum
);

    import mul_mode_pkg::*;

    localparam int SUM_W = ((WIDTH_A > WIDTH_B) ? WIDTH_A : WIDTH_B) + 1;

    logic [SUM_W-1:0] a_ext;
    logic [SUM_W-1:0] b_ext;
    logic [SUM_W-1:0] low_mask;
    mode_e            mode;
    int unsigned      k;

    assign a_ext = SUM_W'(a);
    assign b_ext = SUM_W'(b);
    assign mode  = exact ? MODE_EXACT : MODE_APPROX;

    always_comb begin
        k = lor_bits(mode, LOR);
        for (int i = 0; i < SUM_W; i++) begin
            low_mask[i] = (i < k);
        end
    end

    // low bits cleared before the add, so no carry rises out of them.
    assign sum = ((a_ext & ~low_mask) + (b_ext & ~low_mask))
               | ((a_ext | b_ext) & low_mask);

endmodule

//--- design/approx_mul8.sv
// ----------------------------------------------------------------------
// stage 1 buses into the combiner.
// ----------------------------------------------------------------------

interface diag_if;
    import mul_arith_pkg::*;
    import mul_mode_pkg::*;

    hi_prod_t hi_prod;
    lo_prod_t lo_prod;
    mode_e    mode;
    logic     valid;

    modport source (output hi_prod, lo_prod, mode, valid);
    modport sink   (input  hi_prod, lo_prod, mode, valid);
endinterface

interface cross_if;
    import mul_arith_pkg::*;
    import mul_mode_pkg::*;

    cross_sum_t cross_sum;
    mode_e      mode;
    logic       valid;

    modport source (output cross_sum, mode, valid);
    modport sink   (input  cross_sum, mode, valid);
endinterface

// two-stage approximate 8x8 multiplier.
module approx_mul8 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  mul_mode_pkg::mode_e     mode,
    input  mul_arith_pkg::operand_t a,
    input  mul_arith_pkg::operand_t b,
    output logic                    out_valid,
    output mul_arith_pkg::product_t product
);

    diag_if  diag_bus ();
    cross_if cross_bus ();

    diag_products i_diag_products (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .mode    (mode),
        .a       (a),
        .b       (b),
        .dg      (diag_bus)
    );

    cross_products i_cross_products (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .mode    (mode),
        .a       (a),
        .b       (b),
        .cr      (cross_bus)
    );

    product_combiner i_product_combiner (
        .clk      (clk),
        .rst_n    (rst_n),
        .dg       (diag_bus),
        .cr       (cross_bus),
        .out_valid(out_valid),
        .product  (product)
    );

endmodule

//--- design/diag_products.sv
module diag_products (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  mul_mode_pkg::mode_e     mode,
    input  mul_arith_pkg::operand_t a,
    input  mul_arith_pkg::operand_t b,
    diag_if.source                  dg
);

    import mul_arith_pkg::*;
    import mul_mode_pkg::*;

    logic exact;

    // 3x3 multiplies: [0] is high x high, [1] the low corner of the 5x5.
    logic [2:0] x3 [2];
    logic [2:0] y3 [2];
    logic [5:0] p3 [2];

    // 5x5 pieces, 2-bit high part over a 3-bit low part.
    logic [1:0] al_hi;
    logic [1:0] bl_hi;
    logic [3:0] m_hh;
    logic [4:0] m_hl;
    logic [4:0] m_lh;
    logic [5:0] m_cross;
    logic [7:0] m_sum;

    hi_prod_t hi_prod_d;
    lo_prod_t lo_prod_d;

    assign exact = (mode == MODE_EXACT);

    assign x3[0] = a[`A_W-1:`LO_W];
    assign y3[0] = b[`A_W-1:`LO_W];
    assign x3[1] = a[2:0];
    assign y3[1] = b[2:0];

    // ----------------------------------------------------------------------
    // 3x3 products, 1-bit high over 2-bit low.
    // ----------------------------------------------------------------------

    for (genvar g = 0; g < 2; g++) begin : g_mul3
        logic       q_hh;
        logic [1:0] q_hl;
        logic [1:0] q_lh;
        logic [3:0] q_ll;
        logic [2:0] q_cross;
        logic [3:0] q_sum;

        assign q_hh = x3[g][2] & y3[g][2];
        assign q_hl = x3[g][2] ? y3[g][1:0] : 2'b00;
        assign q_lh = y3[g][2] ? x3[g][1:0] : 2'b00;
        assign q_ll = {2'b00, x3[g][1:0]} * {2'b00, y3[g][1:0]};

        lor_adder #(
            .WIDTH_A(2),
            .WIDTH_B(2),
            .LOR    (`LOR_NONE)
        ) i_cross_add (
            .a    (q_hl),
            .b    (q_lh),
            .exact(exact),
            .sum  (q_cross)
        );

        lor_adder #(
            .WIDTH_A(3),
            .WIDTH_B(3),
            .LOR    (`LOR_NONE)
        ) i_final_add (
            .a    ({q_hh, q_ll[3:2]}),
            .b    (q_cross),
            .exact(exact),
            .sum  (q_sum)
        );

        assign p3[g] = {q_sum, q_ll[1:0]};
    end

    // ----------------------------------------------------------------------
    // 5x5 low product.
    // ----------------------------------------------------------------------

    assign al_hi = a[4:3];
    assign bl_hi = b[4:3];
    assign m_hh  = {2'b00, al_hi} * {2'b00, bl_hi};
    assign m_hl  = {3'b000, al_hi} * {2'b00, b[2:0]};
    assign m_lh  = {2'b00, a[2:0]} * {3'b000, bl_hi};

    lor_adder #(
        .WIDTH_A(5),
        .WIDTH_B(5),
        .LOR    (`LOR_NONE)
    ) i_low_cross_add (
        .a    (m_hl),
        .b    (m_lh),
        .exact(exact),
        .sum  (m_cross)
    );

    lor_adder #(
        .WIDTH_A(7),
        .WIDTH_B(6),
        .LOR    (`LOR_LOW5)
    ) i_low_final_add (
        .a    ({m_hh, p3[1][5:3]}),
        .b    (m_cross),
        .exact(exact),
        .sum  (m_sum)
    );

    // top bit of the sum never sets, the product fits in ten bits.
    assign lo_prod_d = lo_prod_t'({m_sum, p3[1][2:0]});
    assign hi_prod_d = p3[0];

    // stage 1 registers.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dg.valid <= 1'b0;
        end else begin
            dg.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dg.hi_prod <= hi_prod_d;
        dg.lo_prod <= lo_prod_d;
        dg.mode    <= mode;
    end

endmodule

//--- design/cross_products.sv
module cross_products (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  mul_mode_pkg::mode_e     mode,
    input  mul_arith_pkg::operand_t a,
    input  mul_arith_pkg::operand_t b,
    cross_if.source                 cr
);

    import mul_arith_pkg::*;
    import mul_mode_pkg::*;

    logic [`HI_W-1:0] a_hi;
    logic [`HI_W-1:0] b_hi;
    logic [`LO_W-1:0] a_lo;
    logic [`LO_W-1:0] b_lo;
    logic [`A_W-1:0]  p_hl;
    logic [`A_W-1:0]  p_lh;
    cross_sum_t       sum_d;

    assign a_hi = a[`A_W-1:`LO_W];
    assign b_hi = b[`A_W-1:`LO_W];
    assign a_lo = a[`LO_W-1:0];
    assign b_lo = b[`LO_W-1:0];

    // 3x5 terms are exact, each fits the operand width.
    assign p_hl = `A_W'(a_hi) * `A_W'(b_lo);
    assign p_lh = `A_W'(a_lo) * `A_W'(b_hi);

    lor_adder #(
        .WIDTH_A(`A_W),
        .WIDTH_B(`A_W),
        .LOR    (`LOR_NONE)
    ) i_cross_add (
        .a    (p_hl),
        .b    (p_lh),
        .exact(mode == MODE_EXACT),
        .sum  (sum_d)
    );

    // stage 1 registers.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cr.valid <= 1'b0;
        end else begin
            cr.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        cr.cross_sum <= sum_d;
        cr.mode      <= mode;
    end

endmodule

//--- design/product_combiner.sv
module product_combiner (
    input  logic                    clk,
    input  logic                    rst_n,
    diag_if.sink                    dg,
    cross_if.sink                   cr,
    output logic                    out_valid,
    output mul_arith_pkg::product_t product
);

    import mul_arith_pkg::*;
    import mul_mode_pkg::*;

    localparam int UPPER_W = 2*`HI_W + `LO_W;

    // ----------------------------------------------------------------------
    // alignment.
    // ----------------------------------------------------------------------

    // hi_prod lands at bit 10 and the cross sum at bit 5, so both are
    // added to the part of lo_prod at or above bit 5.
    logic [UPPER_W-1:0] upper;
    logic [UPPER_W:0]   upper_sum;
    product_t           product_d;

    assign upper = {dg.hi_prod, dg.lo_prod[2*`LO_W-1:`LO_W]};

    lor_adder #(
        .WIDTH_A(UPPER_W),
        .WIDTH_B(`HI_W + `LO_W + 1),
        .LOR    (`LOR_FINAL)
    ) i_final_add (
        .a    (upper),
        .b    (cr.cross_sum),
        .exact(dg.mode == MODE_EXACT),
        .sum  (upper_sum)
    );

    // low five bits of lo_prod pass straight through.
    assign product_d = product_t'({upper_sum, dg.lo_prod[`LO_W-1:0]});

    // ----------------------------------------------------------------------
    // stage 2 registers.
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dg.valid;
        end
    end

    always_ff @(posedge clk) begin
        product <= product_d;
    end

endmodule

//--- tests/approx_mul8_checker.sv
module approx_mul8_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------------------------------------
    // valid timing.
    // ----------------------------------------------------------------------

    // two register stages between in_valid and out_valid.
    a_latency: assert property (@(posedge clk)
        (rst_n && $past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
        else $error("out_valid is not in_valid delayed by two cycles");

    // ----------------------------------------------------------------------
    // reset state.
    // ----------------------------------------------------------------------

    a_reset_now: assert property (@(posedge clk) $past(!rst_n) |-> !out_valid)
        else $error("out_valid high in the cycle after reset was sampled");

    a_reset_after: assert property (@(posedge clk) $past(!rst_n, 2) |-> !out_valid)
        else $error("out_valid high one cycle after reset release");

endmodule

bind approx_mul8 approx_mul8_checker i_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid)
);

//--- tests/approx_mul8_tb.sv
module approx_mul8_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mul_mode_pkg::*;
    import mul_arith_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    mode_e    mode;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    int       cyc = 0;
    int       tests;
    int       errors;
    integer   seed;

    // scoreboard, one entry per item in flight.
    product_t exp_q[$];
    string    name_q[$];
    int       due_q[$];

    approx_mul8 i_approx_mul8 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .mode     (mode),
        .a        (a),
        .b        (b),
        .out_valid(out_valid),
        .product  (product)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------------------------------------
    // drive one item, 2 ns after the edge.
    // ----------------------------------------------------------------------

    task automatic send_item(input string name, input mode_e m, input operand_t x,
                             input operand_t y, input product_t expected);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        mode     = m;
        a        = x;
        b        = y;
        exp_q.push_back(expected);
        name_q.push_back(name);
        // sampled at the next edge, out_valid rises one edge after that.
        due_q.push_back(cyc + 2);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // scoreboard.
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        product_t expected;
        string    name;
        int       due;
        if (rst_n && out_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("out_valid went high with no item in flight");
                errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                due      = due_q.pop_front();
                tests++;
                assert (cyc == due) else begin
                    $display("test %0s came out at cycle %0d instead of %0d", name, cyc, due);
                    errors++;
                end
                assert (product == expected) else begin
                    $display("** Error %0s: expected %h, actual %h", name, expected, product);
                    errors++;
                end
                if (product == expected && cyc == due) begin
                    $display("ok %0s", name);
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence.
    // ----------------------------------------------------------------------

    initial begin
        int          fd;
        int          n;
        int          m;
        int          waited;
        string       line;
        logic [8*32-1:0] name_buf;
        logic [7:0]  av;
        logic [7:0]  bv;
        logic [15:0] ev;
        logic [31:0] rnd;

        rst_n    = 1'b0;
        in_valid = 1'b0;
        mode     = MODE_EXACT;
        a        = '0;
        b        = '0;
        tests    = 0;
        errors   = 0;
        seed     = 32'h9fe2;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // nothing may come out before the first item.
        repeat (4) begin
            @(negedge clk);
            assert (out_valid == 1'b0) else begin
                $display("out_valid high after reset with no input");
                errors++;
            end
        end

        fd = $fopen("tests/approx_mul8_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            errors++;
        end else begin
            // file vectors go in back to back, modes alternating.
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h", name_buf, m, av, bv, ev);
                    if (n == 5) begin
                        send_item($sformatf("%0s", name_buf), mode_e'(m[0]), av, bv, ev);
                    end
                end
            end
            $fclose(fd);
        end
        idle_cycle();

        // random exact-mode traffic.
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            av  = rnd[7:0];
            bv  = rnd[15:8];
            ev  = {8'h00, av} * {8'h00, bv};
            send_item($sformatf("random_%0d", i), MODE_EXACT, av, bv, ev);
        end
        idle_cycle();

        waited = 0;
        while (exp_q.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("timed out with %0d items still in flight", exp_q.size());
            $display("Errors found");
        end else begin
            @(negedge clk);
            $display("tests: %0d, errors: %0d", tests, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

    // overall watchdog.
    initial begin
        int ticks;
        ticks = 0;
        while (ticks < 5000) begin
            @(posedge clk);
            ticks++;
        end
        $display("simulation ran too long and was stopped");
        $display("Errors found");
        $finish;
    end

endmodule

//--- tests/approx_mul8_input.txt
# columns: test name, mode (0 approx, 1 exact), a, b, expected product; all hex.
# approx rows follow the lower-OR rule with k=1 inside the 5x5 and k=2 in the final adder.
exact_ff_ff    1 ff ff fe01
approx_ff_ff   0 ff ff fdc1
exact_0b_13    1 0b 13 00d1
approx_0b_13   0 0b 13 00c9
exact_13_0b    1 13 0b 00d1
approx_13_0b   0 13 0b 00c9
exact_29_29    1 29 29 0691
approx_29_29   0 29 29 0651
approx_03_03   0 03 03 0009
exact_03_03    1 03 03 0009
approx_ff_01   0 ff 01 00ff
exact_ff_01    1 ff 01 00ff
approx_zero_a  0 00 ff 0000
exact_zero_a   1 00 ff 0000
approx_zero_b  0 a5 00 0000
exact_zero_b   1 a5 00 0000

//--- approx_mul8.f
+incdir+include
design/mul_mode_pkg.sv
design/mul_arith_pkg.sv
design/lor_adder.sv
design/approx_mul8.sv
design/diag_products.sv
design/cross_products.sv
design/product_combiner.sv
tests/approx_mul8_checker.sv
tests/approx_mul8_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f approx_mul8.f \
		--top-module approx_mul8_tb -Mdir obj_dir
	./obj_dir/Vapprox_mul8_tb | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
